// File: mul_settings.svh
/* multiply slice settings
   operand width and depth of the destination tag queue. */

`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// width of rs1, rs2 and the write-back data.
`define MUL_XLEN 32

// tag queue depth.
// it must cover every pipeline stage.
// the design supports 2 to 8.
`define MUL_TAG_DEPTH 4

`endif

// File: mul_pkg.sv
/* multiply slice types
   data widths and funct3 codes shared by decode, unit and write-back. */

`include "mul_settings.svh"

package mul_pkg;

    typedef logic [`MUL_XLEN-1:0] xlen_t;         // register data word.
    typedef logic [`MUL_XLEN:0] ext_operand_t;    // operand plus sign or zero bit.
    typedef logic [2*`MUL_XLEN+1:0] product_t;    // full 33x33 product.
    typedef logic [4:0] reg_addr_t;               // x0 to x31.

    // M extension funct3 codes handled here.
    // codes 4 to 7 are division and are refused by decode.
    typedef enum logic [2:0] {
        MUL    = 3'd0,    // low word, signed x signed.
        MULH   = 3'd1,    // high word, signed x signed.
        MULHSU = 3'd2,    // high word, signed x unsigned.
        MULHU  = 3'd3     // high word, unsigned x unsigned.
    } mul_fn3_t;

endpackage

// File: mul_decode.sv
/* multiply decode
   maps funct3 to operand signedness and word select, refuses division codes. */

`timescale 1ns/100ps
`include "mul_settings.svh"

module mul_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  logic [2:0]            issue_fn3,
    input  mul_pkg::xlen_t        issue_rs1,
    input  mul_pkg::xlen_t        issue_rs2,
    input  logic                  unit_ready,
    input  logic                  tag_space,
    output logic                  issue_ready,
    output logic                  illegal_op,
    output logic                  new_request,
    output mul_pkg::ext_operand_t rs1_ext,
    output mul_pkg::ext_operand_t rs2_ext,
    output logic                  high_sel
);

    logic issue_fire;    // handshake on the issue side.
    logic is_div;        // funct3 4 to 7.
    logic rs1_signed;
    logic rs2_signed;

    assign issue_ready = unit_ready & tag_space;       // both unit and tag queue need room.
    assign issue_fire  = issue_valid & issue_ready;
    assign is_div      = issue_fn3[2];                  // upper half of funct3 is division.
    assign new_request = issue_fire & ~is_div;          // one strobe per accepted multiply.

    assign rs1_signed = (issue_fn3 != mul_pkg::MULHU);  // only mulhu treats rs1 as unsigned.
    assign rs2_signed = (issue_fn3 == mul_pkg::MUL) |
                        (issue_fn3 == mul_pkg::MULH);   // mulhsu and mulhu zero extend rs2.
    assign high_sel   = (issue_fn3 != mul_pkg::MUL);    // everything but mul returns the top.

    // extend to 33 bits so one signed multiplier covers all four codes.
    assign rs1_ext = {issue_rs1[`MUL_XLEN-1] & rs1_signed, issue_rs1};
    assign rs2_ext = {issue_rs2[`MUL_XLEN-1] & rs2_signed, issue_rs2};

    // division is consumed and flagged for one cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            illegal_op <= 1'b0;
        end else begin
            illegal_op <= issue_fire & is_div;           // pulse only and no result follows.
        end
    end

    // a request on the issue port must carry a defined funct3.
    a_fn3_known: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid |-> !$isunknown(issue_fn3)
    );

endmodule

// File: mul_unit.sv
/* two-stage multiply unit
   registered operands, registered 66-bit product, stall when write-back holds. */

`timescale 1ns/100ps
`include "mul_settings.svh"

module mul_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_request,
    input  mul_pkg::ext_operand_t rs1_ext,
    input  mul_pkg::ext_operand_t rs2_ext,
    input  logic                  high_sel,
    input  logic                  accepted,
    output logic                  unit_ready,
    output logic                  done,
    output mul_pkg::xlen_t        result
);

    logic [1:0]            valid;      // per-stage occupancy.
    logic [1:0]            advance;    // stage may load this cycle.
    logic [1:0]            high_r;     // word select travelling with the op.
    mul_pkg::ext_operand_t rs1_r;
    mul_pkg::ext_operand_t rs2_r;
    mul_pkg::product_t     product;

    // stage 1 moves when it is empty or its result is taken.
    assign advance[1] = ~valid[1] | accepted;
    // stage 0 moves when it is empty or stage 1 makes room.
    assign advance[0] = ~valid[0] | advance[1];

    // full and stuck only when both stages hold ops and nothing drains.
    assign unit_ready = accepted | ~(&valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 2'b00;
        end else begin
            if (advance[0]) begin
                valid[0] <= new_request;                 // bubble if nothing issued.
            end
            if (advance[1]) begin
                valid[1] <= valid[0];
            end
        end
    end

    // stage 0 payload.
    always_ff @(posedge clk) begin
        if (advance[0] && new_request) begin
            rs1_r     <= rs1_ext;
            rs2_r     <= rs2_ext;
            high_r[0] <= high_sel;
        end
    end

    // stage 1 payload, signed 33x33 covers the mixed-sign cases.
    always_ff @(posedge clk) begin
        if (advance[1]) begin
            product   <= $signed(rs1_r) * $signed(rs2_r);
            high_r[1] <= high_r[0];
        end
    end

    assign done   = valid[1];                            // two cycles after acceptance.
    assign result = high_r[1] ? product[2*`MUL_XLEN-1:`MUL_XLEN]
                              : product[`MUL_XLEN-1:0];   // bits 65:64 are never returned.

    // write-back may only take a result that is on offer.
    a_accept_needs_done: assert property (
        @(posedge clk) disable iff (rst)
        accepted |-> done
    );

    // a held result must not change until write-back takes it.
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        (done && !accepted) |=> (done && $stable(product) && $stable(high_r[1]))
    );

endmodule

// File: mul_writeback.sv
/* multiply write-back
   in-order destination tag queue, x0 retire, register-file write port. */

`timescale 1ns/100ps
`include "mul_settings.svh"

module mul_writeback (
    input  logic               clk,
    input  logic               rst,
    input  logic               new_request,
    input  mul_pkg::reg_addr_t rd_addr,
    input  logic               done,
    input  mul_pkg::xlen_t     result,
    input  logic               wb_ready,
    output logic               tag_space,
    output logic               accepted,
    output logic               wb_valid,
    output mul_pkg::reg_addr_t wb_rd_addr,
    output mul_pkg::xlen_t     wb_data
);

    localparam int DEPTH = `MUL_TAG_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mul_pkg::reg_addr_t tag_mem [DEPTH];     // destination per op in flight.
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    mul_pkg::reg_addr_t head_tag;
    logic               head_is_x0;

    assign head_tag   = tag_mem[rd_ptr];                 // oldest op is the one in stage 1.
    assign head_is_x0 = (head_tag == '0);
    assign tag_space  = (count != CNT_W'(DEPTH));        // decode stalls when full.

    assign wb_valid   = done & ~head_is_x0;              // x0 writes stay internal.
    assign wb_rd_addr = head_tag;
    assign wb_data    = result;
    assign accepted   = done & (head_is_x0 | wb_ready);  // port handshake or silent drop.

    // tag storage.
    always_ff @(posedge clk) begin
        if (new_request) begin
            tag_mem[wr_ptr] <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (new_request) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (accepted) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({new_request, accepted})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                 // push and pop together.
            endcase
        end
    end

    // every result from the unit must have a tag waiting for it.
    a_done_has_tag: assert property (
        @(posedge clk) disable iff (rst)
        done |-> (count != '0)
    );

endmodule

// File: mul_top.sv
/* multiply slice top
   decode feeds the two-stage unit, which feeds the register-file write-back. */

`timescale 1ns/100ps

module mul_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  logic [2:0]         issue_fn3,
    input  mul_pkg::xlen_t     issue_rs1,
    input  mul_pkg::xlen_t     issue_rs2,
    input  mul_pkg::reg_addr_t issue_rd_addr,
    output logic               illegal_op,
    output logic               wb_valid,
    input  logic               wb_ready,
    output mul_pkg::reg_addr_t wb_rd_addr,
    output mul_pkg::xlen_t     wb_data
);

    logic                  new_request;   // accepted multiply, one cycle.
    logic                  unit_ready;
    logic                  tag_space;
    logic                  high_sel;
    logic                  done;
    logic                  accepted;
    mul_pkg::ext_operand_t rs1_ext;
    mul_pkg::ext_operand_t rs2_ext;
    mul_pkg::xlen_t        result;

    mul_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_fn3   (issue_fn3),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .unit_ready  (unit_ready),
        .tag_space   (tag_space),
        .issue_ready (issue_ready),
        .illegal_op  (illegal_op),
        .new_request (new_request),
        .rs1_ext     (rs1_ext),
        .rs2_ext     (rs2_ext),
        .high_sel    (high_sel)
    );

    mul_unit u_unit (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .rs1_ext     (rs1_ext),
        .rs2_ext     (rs2_ext),
        .high_sel    (high_sel),
        .accepted    (accepted),
        .unit_ready  (unit_ready),
        .done        (done),
        .result      (result)
    );

    // the same strobe pushes rd, so tags stay in result order.
    mul_writeback u_writeback (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .rd_addr     (issue_rd_addr),
        .done        (done),
        .result      (result),
        .wb_ready    (wb_ready),
        .tag_space   (tag_space),
        .accepted    (accepted),
        .wb_valid    (wb_valid),
        .wb_rd_addr  (wb_rd_addr),
        .wb_data     (wb_data)
    );

endmodule

// File: tb_mul_top.sv
/* multiply slice testbench
   replays the trace through issue, applies write-back back-pressure, checks every write. */

`timescale 1ns/100ps

module tb_mul_top;

    localparam int         CLK_PERIOD = 8;
    localparam int         P2_START   = 5;      // first trace line of the stall phase.
    localparam logic [1:0] BP_HIGH    = 2'd0;
    localparam logic [1:0] BP_LOW     = 2'd1;
    localparam logic [1:0] BP_RAND    = 2'd2;

    typedef struct packed {
        logic        timed;    // must complete exactly 2 cycles after acceptance.
        logic [31:0] cycle;    // acceptance cycle.
        logic [31:0] rd;
        logic [31:0] data;
    } exp_t;

    logic               clk;
    logic               rst;
    logic               issue_valid;
    logic               issue_ready;
    logic [2:0]         issue_fn3;
    mul_pkg::xlen_t     issue_rs1;
    mul_pkg::xlen_t     issue_rs2;
    mul_pkg::reg_addr_t issue_rd_addr;
    logic               illegal_op;
    logic               wb_valid;
    logic               wb_ready = 1'b1;
    mul_pkg::reg_addr_t wb_rd_addr;
    mul_pkg::xlen_t     wb_data;

    logic [2:0]  tr_fn3 [$];              // trace columns.
    logic [31:0] tr_rs1 [$];
    logic [31:0] tr_rs2 [$];
    logic [4:0]  tr_rd [$];
    logic [31:0] tr_exp [$];
    exp_t        exp_q [$];               // writes still owed by the DUT.
    int          n_lines = 0;
    int          issue_idx;               // trace line now on the issue port.
    int unsigned cycle_count = 0;
    logic        lat_check = 1'b1;        // ops issued now get the latency check.
    logic [1:0]  bp_mode = BP_HIGH;
    logic        idle_bit = 1'b0;
    logic [31:0] lfsr = 32'h48c1;

    mul_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 32-bit fibonacci with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic load_trace();
        int               fd;
        int               n;
        logic [8*160-1:0] text;
        logic [31:0]      f;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      r;
        logic [31:0]      e;
        fd = $fopen("mul_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open mul_trace.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                // comment and blank lines do not parse as five fields.
                if (n > 0 && $sscanf(text, "%h %h %h %h %h", f, a, b, r, e) == 5) begin
                    tr_fn3.push_back(f[2:0]);
                    tr_rs1.push_back(a);
                    tr_rs2.push_back(b);
                    tr_rd.push_back(r[4:0]);
                    tr_exp.push_back(e);
                end
            end
            $fclose(fd);
        end
    endtask

    // hold one trace line on the issue port until taken or max_wait cycles pass.
    task automatic present_line(input int idx, input int max_wait, output bit taken);
        int waited;
        waited = 0;
        taken  = 1'b0;
        issue_valid   <= 1'b1;
        issue_fn3     <= tr_fn3[idx];
        issue_rs1     <= tr_rs1[idx];
        issue_rs2     <= tr_rs2[idx];
        issue_rd_addr <= tr_rd[idx];
        issue_idx     <= idx;
        while (!taken && waited < max_wait) begin
            @(posedge clk);
            if (issue_ready) taken = 1'b1;           // valid was high all cycle.
            else waited++;
        end
    endtask

    // back-pressure and idle bits both come from the one LFSR.
    always @(posedge clk) begin
        lfsr = lfsr_next(lfsr);
        idle_bit <= lfsr[0];
        case (bp_mode)
            BP_HIGH: wb_ready <= 1'b1;
            BP_LOW:  wb_ready <= 1'b0;
            default: begin
                lfsr = lfsr_next(lfsr);
                wb_ready <= lfsr[0];
            end
        endcase
    end

    // scoreboard that checks every write against the trace.
    always @(posedge clk) begin : monitor
        exp_t head;
        logic div_prev;
        if (rst) begin
            div_prev = 1'b0;
        end else begin
            cycle_count++;
            check_value("illegal_op", 32'(illegal_op), 32'(div_prev));
            if (wb_valid && exp_q.size() == 0) begin
                abort_run("write-back seen with no operation outstanding");
            end else if (wb_valid) begin
                head = exp_q[0];
                check_value("wb_rd_addr", 32'(wb_rd_addr), head.rd);
                check_value("wb_data", wb_data, head.data);
                if (wb_ready) begin
                    if (head.timed) begin
                        check_value("wb latency", cycle_count - head.cycle, 32'd2);
                    end
                    void'(exp_q.pop_front());
                end
            end
            div_prev = issue_valid && issue_ready && tr_fn3[issue_idx][2];  // funct3 4-7.
            if (issue_valid && issue_ready && !tr_fn3[issue_idx][2] &&
                tr_rd[issue_idx] != 0) begin
                exp_q.push_back({lat_check, cycle_count, 32'(tr_rd[issue_idx]),
                                 tr_exp[issue_idx]});
            end
        end
    end

    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 40) @(posedge clk);
        abort_run($sformatf("timeout: run did not finish within %0d cycles", n_lines * 40));
    end

    initial begin
        bit taken;
        int idx;
        int n_taken;
        rst           = 1'b1;
        issue_valid   = 1'b0;
        issue_fn3     = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_rd_addr = '0;
        issue_idx     = 0;
        load_trace();
        if (tr_fn3.size() < P2_START + 3) abort_run("trace too short for the stall phase");
        n_lines = tr_fn3.size();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("wb_valid after reset", 32'(wb_valid), 32'd0);
        check_value("illegal_op after reset", 32'(illegal_op), 32'd0);
        check_value("issue_ready after reset", 32'(issue_ready), 32'd1);
        // back to back with wb_ready high and every op timed.
        for (idx = 0; idx < P2_START; idx++) present_line(idx, n_lines * 40, taken);
        issue_valid <= 1'b0;
        lat_check   <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        // with wb_ready low the pipe fills with two ops and stops.
        bp_mode <= BP_LOW;
        repeat (3) @(posedge clk);
        n_taken = 0;
        idx = P2_START;
        present_line(idx, 6, taken);
        while (taken && idx < n_lines - 1) begin
            n_taken++;
            idx++;
            present_line(idx, 6, taken);
        end
        check_value("ops taken with wb_ready low", n_taken, 32'd2);
        check_value("issue_ready with wb_ready low", 32'(issue_ready), 32'd0);
        // release and then random idles and back-pressure for the rest.
        bp_mode <= BP_RAND;
        present_line(idx, n_lines * 40, taken);
        for (idx = idx + 1; idx < n_lines; idx++) begin
            while (idle_bit) begin
                issue_valid <= 1'b0;
                @(posedge clk);
            end
            present_line(idx, n_lines * 40, taken);
        end
        issue_valid <= 1'b0;
        @(posedge clk);                               // last acceptance is in the queue now.
        while (exp_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);                    // catch any stray write.
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
mul_pkg.sv
mul_decode.sv
mul_unit.sv
mul_writeback.sv
mul_top.sv
tb_mul_top.sv

// File: Makefile
# Verilator build and run of the multiply slice testbench.

VERILATOR ?= verilator
TOP       ?= tb_mul_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: mul_trace.txt
# columns: funct3 rs1 rs2 rd expected_wb_data, all hex.
# lines 0-4 latency phase, 5-7 stall phase, rest random; rd 00 and funct3 4-7 never write back.
0 00000003 00000007 01 00000015
1 80000000 ffffffff 02 00000000
0 80000000 ffffffff 03 80000000
3 ffffffff ffffffff 04 fffffffe
2 ffffffff ffffffff 05 ffffffff
1 7fffffff 7fffffff 06 3fffffff
0 12345678 00000010 07 23456780
3 80000000 00000002 08 00000001
2 80000000 ffffffff 09 80000000
4 00000064 00000007 0a 00000000
1 ffffffff ffffffff 0b 00000000
0 ffffffff ffffffff 00 00000001
1 fffffffe 00000003 0c ffffffff
2 00000003 80000000 0d 00000001
3 00010000 00010000 0e 00000001
5 12345678 9abcdef0 0f 00000000
0 0000ffff 0000ffff 10 fffe0001
2 fffffffe 80000000 00 ffffffff
1 40000000 40000000 11 10000000
3 deadbeef 00000000 12 00000000
0 deadbeef 00000001 13 deadbeef
6 00000001 00000001 14 00000000
7 00000001 00000000 15 00000000
2 80000000 00000001 16 ffffffff
1 80000000 80000000 17 40000000
3 fffffffe 00000002 18 00000001
0 00000000 12345678 00 00000000
0 fffffff6 00000005 19 ffffffce
2 12345678 ffffffff 1a 12345677
1 00000002 c0000000 1f ffffffff
0 00000007 fffffff9 1e ffffffcf
